//--- hdl/cpu_pkg.sv
// Opcode enum, instruction format, pipeline register structs, trace and load port types
package cpu_pkg;

   // Opcodes, any value not listed here is illegal
   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_J    = 5'b00100,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_BNEZ = 5'b01101,
      OP_ST   = 5'b10000,
      OP_LD   = 5'b10001,
      OP_LBI  = 5'b11000,
      OP_ADD  = 5'b11011,
      OP_SUB  = 5'b11100,
      OP_XOR  = 5'b11101,
      OP_AND  = 5'b11110
   } opcode_e;

   typedef struct packed {
      opcode_e    op;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [4:0] low;   // imm5, or rd in low[4:2] for R-type
   } instr_t;

   typedef struct packed {
      logic        valid;
      logic [15:0] pc;
      instr_t      instr;
   } if_id_t;

   typedef struct packed {
      logic        valid;
      logic [15:0] pc;
      opcode_e     op;
      logic [15:0] rdata_a;
      logic [15:0] rdata_b;
      logic [15:0] imm;    // Already sign extended
      logic [2:0]  rd;
      logic        reg_write;
      logic        mem_read;
      logic        mem_write;
      logic        halt;
   } id_ex_t;

   typedef struct packed {
      logic        valid;
      logic [15:0] alu;
      logic [15:0] st_data;
      logic [2:0]  rd;
      logic        reg_write;
      logic        mem_read;
      logic        mem_write;
      logic        halt;
   } ex_mem_t;

   typedef struct packed {
      logic        valid;
      logic [15:0] wdata;
      logic [2:0]  rd;
      logic        reg_write;
      logic        halt;
   } mem_wb_t;

   typedef struct packed {
      logic        valid;
      logic [2:0]  rd;
      logic [15:0] data;
   } wb_trace_t;

   typedef struct packed {
      logic        we;
      logic [15:0] addr;   // Word index
      instr_t      data;
   } imem_wr_t;

   typedef struct packed {
      logic       valid;
      logic [2:0] idx;
   } reg_dst_t;

endpackage

//--- hdl/fetch.sv
// Fetch stage with instruction memory, load port, PC and fetch/decode register
`default_nettype none
module fetch #(
   parameter int IMEM_DEPTH = 256
) (
   input  wire                clk,
   input  wire                rst_n,
   input  logic               run,
   input  cpu_pkg::imem_wr_t  imem_wr,
   input  logic               stall,
   input  logic               redirect,
   input  logic [15:0]        target,
   input  logic               halt_seen,
   output cpu_pkg::if_id_t    if_id
);

   localparam int IAW = $clog2(IMEM_DEPTH);   // Depth is a power of two, so slicing wraps

   cpu_pkg::instr_t imem [IMEM_DEPTH];
   logic [15:0]     pc;
   logic            fetch_en;

   assign fetch_en = run & ~halt_seen;

   // Program load, only while the machine is idle
   always_ff @(posedge clk) begin
      if (imem_wr.we && !run)
         imem[imem_wr.addr[IAW-1:0]] <= imem_wr.data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc    <= '0;
         if_id <= '0;
      end else if (redirect) begin
         pc          <= target;   // Taken branch or jump wins over a stall
         if_id.valid <= 1'b0;
      end else if (stall) begin
         pc    <= pc;
         if_id <= if_id;
      end else if (fetch_en) begin
         if_id.valid <= 1'b1;
         if_id.pc    <= pc;
         if_id.instr <= imem[pc[IAW-1:0]];
         pc          <= pc + 16'd1;
      end else begin
         if_id.valid <= 1'b0;     // Idle or halted
      end
   end

endmodule
`default_nettype wire

//--- hdl/decode.sv
// Decode with control decoding, register file, immediates, illegal opcode flag, ID/EX register
`default_nettype none
module decode (
   input  wire                 clk,
   input  wire                 rst_n,
   input  cpu_pkg::if_id_t     if_id,
   input  logic                stall,
   input  logic                redirect,
   input  cpu_pkg::wb_trace_t  wb,
   output cpu_pkg::id_ex_t     id_ex,
   output cpu_pkg::reg_dst_t   src_a,
   output cpu_pkg::reg_dst_t   src_b,
   output logic                err
);

   logic [15:0]     rf [8];
   cpu_pkg::instr_t ins;
   logic [15:0]     imm;
   logic [2:0]      rd;
   logic            use_a, use_b;
   logic            reg_write, mem_read, mem_write, halt, illegal;

   assign ins = if_id.instr;

   always_comb begin
      imm       = {{11{ins.low[4]}}, ins.low};   // imm5 by default
      rd        = ins.rt;
      use_a     = 1'b0;
      use_b     = 1'b0;
      reg_write = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      halt      = 1'b0;
      illegal   = 1'b0;
      case (ins.op)
         cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_XOR: begin
            rd        = ins.low[4:2];
            use_a     = 1'b1;
            use_b     = 1'b1;
            reg_write = 1'b1;
         end
         cpu_pkg::OP_ADDI: begin
            use_a     = 1'b1;
            reg_write = 1'b1;
         end
         cpu_pkg::OP_LBI: begin
            imm       = {{8{ins.rt[2]}}, ins.rt, ins.low};
            rd        = ins.rs;
            reg_write = 1'b1;
         end
         cpu_pkg::OP_LD: begin
            use_a     = 1'b1;
            reg_write = 1'b1;
            mem_read  = 1'b1;
         end
         cpu_pkg::OP_ST: begin
            use_a     = 1'b1;
            use_b     = 1'b1;     // Store data comes from rt
            mem_write = 1'b1;
         end
         cpu_pkg::OP_BEQZ, cpu_pkg::OP_BNEZ: begin
            imm   = {{8{ins.rt[2]}}, ins.rt, ins.low};
            use_a = 1'b1;
         end
         cpu_pkg::OP_J:    imm = {{5{ins.rs[2]}}, ins.rs, ins.rt, ins.low};
         cpu_pkg::OP_NOP:  ;
         cpu_pkg::OP_HALT: halt = 1'b1;
         default:          illegal = 1'b1;   // Runs on as a NOP
      endcase
   end

   assign src_a = '{valid: if_id.valid & use_a, idx: ins.rs};
   assign src_b = '{valid: if_id.valid & use_b, idx: ins.rt};

   // Architectural registers start at zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++)
            rf[i] <= '0;
      end else if (wb.valid) begin
         rf[wb.rd] <= wb.data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         id_ex <= '0;
         err   <= 1'b0;
      end else begin
         err <= err | (if_id.valid & illegal & ~redirect);
         if (redirect || stall || !if_id.valid) begin
            id_ex <= '0;          // Bubble
         end else begin
            id_ex.valid     <= 1'b1;
            id_ex.pc        <= if_id.pc;
            id_ex.op        <= illegal ? cpu_pkg::OP_NOP : ins.op;
            id_ex.rdata_a   <= rf[ins.rs];
            id_ex.rdata_b   <= rf[ins.rt];
            id_ex.imm       <= imm;
            id_ex.rd        <= rd;
            id_ex.reg_write <= reg_write;
            id_ex.mem_read  <= mem_read;
            id_ex.mem_write <= mem_write;
            id_ex.halt      <= halt;
         end
      end
   end

endmodule
`default_nettype wire

//--- hdl/hazard_unit.sv
// Read-after-write hazard detection against the execute, memory and writeback destinations
`default_nettype none
module hazard_unit (
   input  cpu_pkg::reg_dst_t src_a,
   input  cpu_pkg::reg_dst_t src_b,
   input  cpu_pkg::reg_dst_t dst_ex,
   input  cpu_pkg::reg_dst_t dst_mem,
   input  cpu_pkg::reg_dst_t dst_wb,
   output logic              stall
);

   logic hit_ex, hit_mem, hit_wb;

   function automatic logic hit(input cpu_pkg::reg_dst_t src, input cpu_pkg::reg_dst_t dst);
      return src.valid && dst.valid && (src.idx == dst.idx);
   endfunction

   // Producers still ahead of the register file
   assign hit_ex  = hit(src_a, dst_ex)  | hit(src_b, dst_ex);
   assign hit_mem = hit(src_a, dst_mem) | hit(src_b, dst_mem);

   // Writeback lands at the end of this cycle, so decode waits one more
   // cycle and then reads the updated register
   assign hit_wb  = hit(src_a, dst_wb)  | hit(src_b, dst_wb);

   assign stall = hit_ex | hit_mem | hit_wb;

endmodule
`default_nettype wire

//--- hdl/execute.sv
// Execute stage with ALU, branch and jump resolution, redirect and execute/memory register
`default_nettype none
module execute (
   input  wire                clk,
   input  wire                rst_n,
   input  cpu_pkg::id_ex_t    id_ex,
   output cpu_pkg::ex_mem_t   ex_mem,
   output cpu_pkg::reg_dst_t  dst_ex,
   output logic               redirect,
   output logic [15:0]        target
);

   logic [15:0] a, b, result;
   logic        taken;

   assign a = id_ex.rdata_a;
   assign b = id_ex.rdata_b;

   always_comb begin
      result = '0;
      taken  = 1'b0;
      case (id_ex.op)
         cpu_pkg::OP_ADD:  result = a + b;
         cpu_pkg::OP_SUB:  result = a - b;
         cpu_pkg::OP_AND:  result = a & b;
         cpu_pkg::OP_XOR:  result = a ^ b;
         cpu_pkg::OP_ADDI, cpu_pkg::OP_LD, cpu_pkg::OP_ST:
            result = a + id_ex.imm;          // Also the data address
         cpu_pkg::OP_LBI:  result = id_ex.imm;
         cpu_pkg::OP_BEQZ: taken = (a == 16'd0);
         cpu_pkg::OP_BNEZ: taken = (a != 16'd0);
         cpu_pkg::OP_J:    taken = 1'b1;
         default:          result = '0;
      endcase
   end

   // Word PC, offset relative to the next instruction
   assign target   = id_ex.pc + 16'd1 + id_ex.imm;
   assign redirect = id_ex.valid & taken;

   assign dst_ex = '{valid: id_ex.valid & id_ex.reg_write, idx: id_ex.rd};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_mem <= '0;
      end else begin
         ex_mem.valid     <= id_ex.valid;
         ex_mem.alu       <= result;
         ex_mem.st_data   <= b;
         ex_mem.rd        <= id_ex.rd;
         ex_mem.reg_write <= id_ex.valid & id_ex.reg_write;
         ex_mem.mem_read  <= id_ex.valid & id_ex.mem_read;
         ex_mem.mem_write <= id_ex.valid & id_ex.mem_write;
         ex_mem.halt      <= id_ex.valid & id_ex.halt;
      end
   end

endmodule
`default_nettype wire

//--- hdl/mem_wb.sv
// Memory and writeback stages with data memory, memory/writeback register, trace and halt latch
`default_nettype none
module mem_wb #(
   parameter int DMEM_DEPTH = 256
) (
   input  wire                 clk,
   input  wire                 rst_n,
   input  cpu_pkg::ex_mem_t    ex_mem,
   output cpu_pkg::reg_dst_t   dst_mem,
   output cpu_pkg::reg_dst_t   dst_wb,
   output cpu_pkg::wb_trace_t  wb,
   output logic                halt_seen,
   output logic                halted
);

   localparam int DAW = $clog2(DMEM_DEPTH);

   logic [15:0]      dmem [DMEM_DEPTH];
   logic [DAW-1:0]   addr;
   cpu_pkg::mem_wb_t mem_wb_q;
   logic             halt_q;

   assign addr = ex_mem.alu[DAW-1:0];   // Wraps modulo the depth

   // Halt counts from the cycle it reaches writeback
   assign halted    = halt_q | (mem_wb_q.valid & mem_wb_q.halt);
   assign halt_seen = halted;

   // Younger stores behind a HALT are dropped
   always_ff @(posedge clk) begin
      if (ex_mem.valid && ex_mem.mem_write && !halted)
         dmem[addr] <= ex_mem.st_data;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_wb_q <= '0;
         halt_q   <= 1'b0;
      end else begin
         halt_q             <= halted;
         mem_wb_q.valid     <= ex_mem.valid;
         mem_wb_q.wdata     <= ex_mem.mem_read ? dmem[addr] : ex_mem.alu;
         mem_wb_q.rd        <= ex_mem.rd;
         mem_wb_q.reg_write <= ex_mem.reg_write;
         mem_wb_q.halt      <= ex_mem.halt;
      end
   end

   assign dst_mem = '{valid: ex_mem.valid & ex_mem.reg_write, idx: ex_mem.rd};
   assign dst_wb  = '{valid: mem_wb_q.valid & mem_wb_q.reg_write, idx: mem_wb_q.rd};

   // Register write and trace are the same strobe
   assign wb.valid = mem_wb_q.valid & mem_wb_q.reg_write & ~halted;
   assign wb.rd    = mem_wb_q.rd;
   assign wb.data  = mem_wb_q.wdata;

endmodule
`default_nettype wire

//--- hdl/proc.sv
// Top level joining fetch, decode, hazard unit, execute and memory/writeback
`default_nettype none
module proc #(
   parameter int IMEM_DEPTH = 256,
   parameter int DMEM_DEPTH = 256
) (
   input  wire                 clk,
   input  wire                 rst_n,
   input  logic                run,
   input  cpu_pkg::imem_wr_t   imem_wr,
   output cpu_pkg::wb_trace_t  trace,
   output logic                halted,
   output logic                err
);

   cpu_pkg::if_id_t    if_id;
   cpu_pkg::id_ex_t    id_ex;
   cpu_pkg::ex_mem_t   ex_mem;
   cpu_pkg::wb_trace_t wb;
   cpu_pkg::reg_dst_t  src_a, src_b;
   cpu_pkg::reg_dst_t  dst_ex, dst_mem, dst_wb;
   logic               stall;
   logic               redirect;
   logic [15:0]        target;
   logic               halt_seen;

   assign trace = wb;   // Trace is the register file write port

   fetch #(.IMEM_DEPTH(IMEM_DEPTH)) fetch0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .run       (run),
      .imem_wr   (imem_wr),
      .stall     (stall),
      .redirect  (redirect),
      .target    (target),
      .halt_seen (halt_seen),
      .if_id     (if_id)
   );

   decode decode0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .if_id    (if_id),
      .stall    (stall),
      .redirect (redirect),
      .wb       (wb),
      .id_ex    (id_ex),
      .src_a    (src_a),
      .src_b    (src_b),
      .err      (err)
   );

   hazard_unit hdu0 (
      .src_a   (src_a),
      .src_b   (src_b),
      .dst_ex  (dst_ex),
      .dst_mem (dst_mem),
      .dst_wb  (dst_wb),
      .stall   (stall)
   );

   execute execute0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .id_ex    (id_ex),
      .ex_mem   (ex_mem),
      .dst_ex   (dst_ex),
      .redirect (redirect),
      .target   (target)
   );

   mem_wb #(.DMEM_DEPTH(DMEM_DEPTH)) mem_wb0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .ex_mem    (ex_mem),
      .dst_mem   (dst_mem),
      .dst_wb    (dst_wb),
      .wb        (wb),
      .halt_seen (halt_seen),
      .halted    (halted)
   );

endmodule
`default_nettype wire

//--- sim/proc_props.sv
// Concurrent assertions on the proc outputs and their bind to proc
module proc_props (
   input logic               clk,
   input logic               rst_n,
   input cpu_pkg::wb_trace_t trace,
   input logic               halted,
   input logic               err
);
   timeunit 1ns;
   timeprecision 100ps;

   // Sticky flags
   halted_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(halted))
      else $error("halted fell while out of reset");
   err_sticky: assert property (@(posedge clk) disable iff (!rst_n) !$fell(err))
      else $error("err fell while out of reset");

   no_trace_halted: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !trace.valid)
      else $error("trace.valid high while halted");

   reset_quiet: assert property (@(posedge clk) !rst_n |-> !trace.valid && !halted && !err)
      else $error("outputs not low during reset");

endmodule

bind proc proc_props props0 (
   .clk    (clk),
   .rst_n  (rst_n),
   .trace  (trace),
   .halted (halted),
   .err    (err)
);

//--- sim/proc_tb.sv
// Testbench for proc with random programs, instruction-set model, compare tasks and watchdog
module proc_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int IMEM_DEPTH = 256;
   localparam int DMEM_DEPTH = 256;
   localparam int NUM_TESTS  = 10;
   localparam int PROG_LEN   = 48;
   localparam int PAD        = 4;   // HALT words behind each program for the fetch run-ahead

   logic               clk;
   logic               rst_n;
   logic               run;
   cpu_pkg::imem_wr_t  imem_wr;
   cpu_pkg::wb_trace_t trace;
   logic               halted;
   logic               err;

   int                 seed = 56;
   int                 test_errors;
   int                 n_pass;
   int                 n_fail;
   cpu_pkg::instr_t    prog [PROG_LEN];
   logic [15:0]        mem_model [DMEM_DEPTH];   // Persists across tests like the DUT memory
   cpu_pkg::wb_trace_t exp_q [$];
   cpu_pkg::wb_trace_t got_q [$];
   logic               exp_err;

   proc #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) DUT (
      .clk     (clk),
      .rst_n   (rst_n),
      .run     (run),
      .imem_wr (imem_wr),
      .trace   (trace),
      .halted  (halted),
      .err     (err)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Budget grows with the number and length of the programs
   initial begin
      repeat (NUM_TESTS * (PROG_LEN * 4 + 20)) @(posedge clk);
      $display("Watchdog expired before the last test finished");
      $display("tests failed");
      $finish;
   end

   function automatic int rnd(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // Kind 0 ALU mix, 1 memory, 2 dependent chains, 3 branches, 4 illegal opcodes
   function automatic cpu_pkg::instr_t make_instr(input int kind, input int pc);
      cpu_pkg::instr_t ins;
      int              r;
      int              sel;
      int              span;
      int              nregs;
      int              srcs;
      nregs = (kind == 2) ? 3 : 7;      // r7 stays zero as the memory base
      srcs  = (kind == 2) ? 3 : 8;
      span  = PROG_LEN - 2 - pc;        // Forward reach up to the final HALT
      r     = rnd(16);
      ins   = cpu_pkg::instr_t'(16'(rnd(65536)));
      ins.rs = 3'(rnd(srcs));
      ins.rt = 3'(rnd(srcs));
      case (kind)
         1:       sel = (r < 8) ? 6 + (r % 2) : rnd(12);
         3:       sel = (r < 9) ? 8 + (r % 3) : rnd(12);
         4:       sel = (r < 3) ? 12 : rnd(12);
         default: sel = rnd(12);
      endcase
      case (sel)
         0:  ins.op = cpu_pkg::OP_ADD;
         1:  ins.op = cpu_pkg::OP_SUB;
         2:  ins.op = cpu_pkg::OP_AND;
         3:  ins.op = cpu_pkg::OP_XOR;
         4:  ins.op = cpu_pkg::OP_ADDI;
         5:  ins.op = cpu_pkg::OP_LBI;
         6:  ins.op = cpu_pkg::OP_LD;
         7:  ins.op = cpu_pkg::OP_ST;
         8:  ins.op = cpu_pkg::OP_BEQZ;
         9:  ins.op = cpu_pkg::OP_BNEZ;
         10: ins.op = cpu_pkg::OP_J;
         11: ins.op = cpu_pkg::OP_NOP;
         default: begin
            case (rnd(4))   // Unassigned encodings
               0:       ins.op = cpu_pkg::opcode_e'(5'b00010);
               1:       ins.op = cpu_pkg::opcode_e'(5'b00101);
               2:       ins.op = cpu_pkg::opcode_e'(5'b01001);
               default: ins.op = cpu_pkg::opcode_e'(5'b11111);
            endcase
         end
      endcase
      if (sel <= 3)
         ins.low[4:2] = 3'(rnd(nregs));
      else if (sel == 4)
         ins.rt = 3'(rnd(nregs));
      else if (sel == 5)
         ins.rs = 3'(rnd(nregs));
      else if (sel == 6 || sel == 7) begin
         ins.rs = 3'd7;
         if (sel == 6)
            ins.rt = 3'(rnd(nregs));
      end else if (sel == 8 || sel == 9)
         {ins.rt, ins.low} = 8'(rnd(((span > 127) ? 127 : span) + 1));
      else if (sel == 10)
         {ins.rs, ins.rt, ins.low} = 11'(rnd(span + 1));
      return ins;
   endfunction

   task automatic build_program(input int kind, input bit preamble);
      int start;
      start = 0;
      if (preamble) begin
         // Zero every data word that a base-r7 access can reach
         for (int i = 0; i < 32; i++)
            prog[i] = '{op: cpu_pkg::OP_ST, rs: 3'd7, rt: 3'd7, low: 5'(i)};
         start = 32;
      end
      for (int pc = start; pc < PROG_LEN - 1; pc++)
         prog[pc] = make_instr(kind, pc);
      prog[PROG_LEN-1] = '{op: cpu_pkg::OP_HALT, rs: 3'd0, rt: 3'd0, low: 5'd0};
   endtask

   // Sequential instruction-set model stepping one instruction at a time
   task automatic run_model();
      cpu_pkg::instr_t ins;
      logic [15:0]     rf [8];
      logic [15:0]     a;
      logic [15:0]     b;
      logic [15:0]     imm5;
      logic [15:0]     addr;
      logic [15:0]     res;
      logic [2:0]      rd;
      logic            wr;
      int              pc;
      int              steps;
      exp_q.delete();
      exp_err = 1'b0;
      for (int i = 0; i < 8; i++)
         rf[i] = '0;
      pc    = 0;
      steps = 0;
      while (steps < 4 * PROG_LEN) begin
         ins   = prog[pc];
         a     = rf[ins.rs];
         b     = rf[ins.rt];
         imm5  = 16'(int'($signed(ins.low)));
         addr  = a + imm5;
         wr    = 1'b0;
         rd    = ins.rt;
         res   = '0;
         pc    = pc + 1;
         steps = steps + 1;
         case (ins.op)
            cpu_pkg::OP_ADD: begin
               wr  = 1'b1;
               rd  = ins.low[4:2];
               res = a + b;
            end
            cpu_pkg::OP_SUB: begin
               wr  = 1'b1;
               rd  = ins.low[4:2];
               res = a - b;
            end
            cpu_pkg::OP_AND: begin
               wr  = 1'b1;
               rd  = ins.low[4:2];
               res = a & b;
            end
            cpu_pkg::OP_XOR: begin
               wr  = 1'b1;
               rd  = ins.low[4:2];
               res = a ^ b;
            end
            cpu_pkg::OP_ADDI: begin
               wr  = 1'b1;
               res = a + imm5;
            end
            cpu_pkg::OP_LBI: begin
               wr  = 1'b1;
               rd  = ins.rs;
               res = 16'(int'($signed({ins.rt, ins.low})));
            end
            cpu_pkg::OP_LD: begin
               wr  = 1'b1;
               res = mem_model[addr % DMEM_DEPTH];
            end
            cpu_pkg::OP_ST:   mem_model[addr % DMEM_DEPTH] = b;
            cpu_pkg::OP_BEQZ: if (a == 16'd0) pc = pc + int'($signed({ins.rt, ins.low}));
            cpu_pkg::OP_BNEZ: if (a != 16'd0) pc = pc + int'($signed({ins.rt, ins.low}));
            cpu_pkg::OP_J:    pc = pc + int'($signed({ins.rs, ins.rt, ins.low}));
            cpu_pkg::OP_NOP:  ;
            cpu_pkg::OP_HALT: break;
            default:          exp_err = 1'b1;   // Then behaves as a NOP
         endcase
         if (wr) begin
            rf[rd] = res;
            exp_q.push_back('{valid: 1'b1, rd: rd, data: res});
         end
      end
   endtask

   task automatic check_trace(input cpu_pkg::wb_trace_t got, input cpu_pkg::wb_trace_t exp);
      if (got.rd !== exp.rd || got.data !== exp.data) begin
         $display("** Error at %0d ns: trace got rd=%0d data=%h, expected rd=%0d data=%h",
                  $time, got.rd, got.data, exp.rd, exp.data);
         test_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s got %b, expected %b", $time, name, got, exp);
         test_errors++;
      end
   endtask

   task automatic load_program();
      cpu_pkg::instr_t halt_w;
      halt_w = '{op: cpu_pkg::OP_HALT, rs: 3'd0, rt: 3'd0, low: 5'd0};
      for (int i = 0; i < PROG_LEN + PAD; i++) begin
         @(posedge clk);
         imem_wr <= '{we: 1'b1, addr: 16'(i), data: (i < PROG_LEN) ? prog[i] : halt_w};
      end
      @(posedge clk);
      imem_wr.we <= 1'b0;
      run        <= 1'b1;
   endtask

   task automatic run_test(input int t);
      int kind;
      kind        = t % 5;
      test_errors = 0;
      build_program(kind, t == 0);
      run_model();
      @(posedge clk);
      rst_n <= 1'b0;
      run   <= 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      load_program();
      got_q.delete();
      do begin
         @(negedge clk);
         if (trace.valid)
            got_q.push_back(trace);
      end while (!halted);
      check_flag("err", err, exp_err);
      for (int i = 0; i < got_q.size() && i < exp_q.size(); i++)
         check_trace(got_q[i], exp_q[i]);
      if (got_q.size() < exp_q.size()) begin
         $display("Test %0d: %0d register writes never appeared on the trace",
                  t, exp_q.size() - got_q.size());
         test_errors++;
      end else if (got_q.size() > exp_q.size()) begin
         $display("Test %0d: %0d unexpected register writes appeared on the trace",
                  t, got_q.size() - exp_q.size());
         test_errors++;
      end
      repeat (4) begin
         @(negedge clk);
         if (trace.valid) begin
            $display("Test %0d: a register write appeared after halted at %0d ns", t, $time);
            test_errors++;
         end
      end
      check_flag("halted", halted, 1'b1);   // Must stay set after the HALT
      if (test_errors == 0)
         n_pass++;
      else
         n_fail++;
      $display("Test %0d kind %0d: %0d writes, %0d errors", t, kind, got_q.size(), test_errors);
   endtask

   initial begin
      rst_n   = 1'b0;
      run     = 1'b0;
      imem_wr = '0;
      n_pass  = 0;
      n_fail  = 0;
      for (int t = 0; t < NUM_TESTS; t++)
         run_test(t);
      $display("%0d tests run, %0d passed, %0d failed", NUM_TESTS, n_pass, n_fail);
      if (n_fail == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- files.f
hdl/cpu_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/hazard_unit.sv
hdl/execute.sv
hdl/mem_wb.sv
hdl/proc.sv
sim/proc_props.sv
sim/proc_tb.sv

//--- Makefile
TOP = proc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
